// ==== aesRoundCore.f ====
+incdir+source
+incdir+sim
source/aesPkg.sv
source/aesSbox.sv
source/keyXorLoader.sv
source/subBytesSerial.sv
source/shiftMixColumns.sv
source/aesRoundCore.sv
sim/clockGen.sv
sim/aesRoundCoreTb.sv

// ==== sim/aesRefModel.svh ====
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Reference AES round, byte k at row k mod 4, column k div 4
////////////////////////////////////////////////////////////////////////////

// Carry-less product, then reduction by 0x11B from the top bit down
function automatic logic [7:0] gfProduct(input logic [7:0] a, input logic [7:0] b);
    logic [15:0] wide;
    wide = '0;
    for (int i = 0; i < 8; i++) begin
        if (b[i]) begin
            wide = wide ^ (16'(a) << i);
        end
    end
    for (int i = 15; i >= 8; i--) begin
        if (wide[i]) begin
            wide = wide ^ (16'h11B << (i - 8));
        end
    end
    return wide[7:0];
endfunction

// Inverse found by search, zero maps to zero
function automatic logic [7:0] sboxRef(input logic [7:0] x);
    logic [7:0] inv;
    logic [7:0] affineConst;
    logic [7:0] s;
    inv         = 8'h00;
    affineConst = 8'h63;
    for (int y = 1; y < 256; y++) begin
        if (gfProduct(x, 8'(y)) == 8'h01) begin
            inv = 8'(y);
        end
    end
    // FIPS-197 affine map, bit by bit
    for (int i = 0; i < 8; i++) begin
        s[i] = inv[i] ^ inv[(i+4)%8] ^ inv[(i+5)%8] ^ inv[(i+6)%8] ^ inv[(i+7)%8]
             ^ affineConst[i];
    end
    return s;
endfunction

// Row r moves left by r columns
function automatic logic [`AES_STATE_WIDTH-1:0] shiftRowsRef(
    input logic [`AES_STATE_WIDTH-1:0] s
);
    logic [`AES_STATE_WIDTH-1:0] r;
    for (int col = 0; col < 4; col++) begin
        for (int row = 0; row < 4; row++) begin
            r[`AES_STATE_WIDTH-1-8*(4*col+row) -: 8] =
                s[`AES_STATE_WIDTH-1-8*(4*((col+row)%4)+row) -: 8];
        end
    end
    return r;
endfunction

// Fixed matrix 2 3 1 1 / 1 2 3 1 / 1 1 2 3 / 3 1 1 2
function automatic logic [`AES_STATE_WIDTH-1:0] mixColumnsRef(
    input logic [`AES_STATE_WIDTH-1:0] s
);
    logic [`AES_STATE_WIDTH-1:0] r;
    logic [7:0] a0, a1, a2, a3;
    for (int col = 0; col < 4; col++) begin
        a0 = s[127-32*col -: 8];
        a1 = s[119-32*col -: 8];
        a2 = s[111-32*col -: 8];
        a3 = s[103-32*col -: 8];
        r[127-32*col -: 8] = gfProduct(8'h02, a0) ^ gfProduct(8'h03, a1) ^ a2 ^ a3;
        r[119-32*col -: 8] = a0 ^ gfProduct(8'h02, a1) ^ gfProduct(8'h03, a2) ^ a3;
        r[111-32*col -: 8] = a0 ^ a1 ^ gfProduct(8'h02, a2) ^ gfProduct(8'h03, a3);
        r[103-32*col -: 8] = gfProduct(8'h03, a0) ^ a1 ^ a2 ^ gfProduct(8'h02, a3);
    end
    return r;
endfunction

// AddRoundKey, SubBytes, ShiftRows, MixColumns
function automatic logic [`AES_STATE_WIDTH-1:0] aesRoundRef(
    input logic [`AES_STATE_WIDTH-1:0] plain,
    input logic [`AES_STATE_WIDTH-1:0] key
);
    logic [`AES_STATE_WIDTH-1:0] sub;
    for (int k = 0; k < `AES_BYTES; k++) begin
        sub[`AES_STATE_WIDTH-1-8*k -: 8] =
            sboxRef(plain[`AES_STATE_WIDTH-1-8*k -: 8] ^ key[`AES_STATE_WIDTH-1-8*k -: 8]);
    end
    return mixColumnsRef(shiftRowsRef(sub));
endfunction

`endif

// ==== sim/aesRoundCoreTb.sv ====
`include "aes_defs.svh"

module aesRoundCoreTb;

    localparam int clockPeriod  = 8;
    localparam int resetCycles  = 10;
    localparam int randomRuns   = 20;
    // Known, zero, random, and two runs for the enable test
    localparam int totalRuns    = 4 + randomRuns;
    localparam int cyclesPerRun = 40;
    localparam int timeoutTime  = totalRuns * cyclesPerRun * clockPeriod
                                + resetCycles * clockPeriod;
    localparam int roundLatency = 32;
    localparam logic [31:0] randomSeed = 32'h6a97c20a;

    // FIPS-197 appendix B round 1 after MixColumns
    localparam logic [`AES_STATE_WIDTH-1:0] knownPlain =
        128'h3243f6a8885a308d313198a2e0370734;
    localparam logic [`AES_STATE_WIDTH-1:0] knownKey =
        128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam logic [`AES_STATE_WIDTH-1:0] knownResult =
        128'h046681e5e0cb199a48f8d37a2806264c;

    logic                        clock;
    logic                        rstN;
    logic                        enable;
    logic [7:0]                  inData;
    logic [7:0]                  keyByte;
    logic [`AES_STATE_WIDTH-1:0] message;
    logic                        busy;
    logic                        done;

    // Blocks in flight until the done monitor pops them
    string                       nameQueue[$];
    logic [`AES_STATE_WIDTH-1:0] expectQueue[$];
    int                          startQueue[$];

    int                          errorCount = 0;
    int                          testsPassed = 0;
    int                          testsFailed = 0;
    int                          testErrorBase;
    string                       currentTest;
    int                          cycleCount = 0;
    logic [`AES_STATE_WIDTH-1:0] lastResult;
    logic [`AES_STATE_WIDTH-1:0] stimPlain;
    logic [`AES_STATE_WIDTH-1:0] stimKey;

    clockGen clockSource (
        .clock (clock)
    );

    aesRoundCore aesRoundCore_i (
        .clock   (clock),
        .rstN    (rstN),
        .enable  (enable),
        .inData  (inData),
        .keyByte (keyByte),
        .message (message),
        .busy    (busy),
        .done    (done)
    );

    `include "aesRefModel.svh"

    ////////////////////////////////////////////////////////////////////////////
    // Checking and bookkeeping
    ////////////////////////////////////////////////////////////////////////////

    task automatic checkValue(input string testName,
                              input logic [`AES_STATE_WIDTH-1:0] expected,
                              input logic [`AES_STATE_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %0h actual %0h", testName, expected, actual);
            errorCount++;
        end
    endtask

    task automatic startTest(input string testName);
        currentTest   = testName;
        testErrorBase = errorCount;
    endtask

    task automatic finishTest();
        if (errorCount == testErrorBase) begin
            testsPassed++;
            $display("[ok]   %s", currentTest);
        end else begin
            testsFailed++;
            $display("[fail] %s, %0d errors", currentTest, errorCount - testErrorBase);
        end
    endtask

    function automatic logic [`AES_STATE_WIDTH-1:0] randomBlock();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // Rising edges counted so far and read only on falling edges
    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
    end

    // Done monitor checks result and latency of the oldest block
    always @(negedge clock) begin
        if (rstN && done) begin
            if (expectQueue.size() == 0) begin
                $display("ERROR: done pulse seen with no block outstanding");
                errorCount++;
            end else begin
                checkValue(nameQueue[0], expectQueue[0], message);
                checkValue({nameQueue[0], " latency"}, roundLatency,
                           cycleCount - startQueue[0]);
                nameQueue.delete(0);
                expectQueue.delete(0);
                startQueue.delete(0);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // One block with byte k presented before edge k
    ////////////////////////////////////////////////////////////////////////////

    task automatic runBlock(input string testName,
                            input logic [`AES_STATE_WIDTH-1:0] plain,
                            input logic [`AES_STATE_WIDTH-1:0] key,
                            input logic [`AES_STATE_WIDTH-1:0] expected,
                            input bit pokeEnable);
        bit doneSeen;
        doneSeen = 1'b0;
        @(negedge clock);
        nameQueue.push_back(testName);
        expectQueue.push_back(expected);
        // Next rising edge is edge 0
        startQueue.push_back(cycleCount + 1);
        enable  = 1'b1;
        inData  = plain[`AES_STATE_WIDTH-1 -: 8];
        keyByte = key[`AES_STATE_WIDTH-1 -: 8];
        for (int k = 1; k < `AES_BYTES; k++) begin
            @(negedge clock);
            checkValue({testName, " busy"}, 1'b1, busy);
            checkValue({testName, " message hold"}, lastResult, message);
            enable  = pokeEnable;
            inData  = plain[`AES_STATE_WIDTH-1-8*k -: 8];
            keyByte = key[`AES_STATE_WIDTH-1-8*k -: 8];
        end
        // Substitution and mixing
        while (!doneSeen) begin
            @(negedge clock);
            checkValue({testName, " busy"}, 1'b1, busy);
            // Junk on the byte inputs must be ignored now
            if (pokeEnable) begin
                inData  = 8'($urandom);
                keyByte = 8'($urandom);
            end
            if (done) begin
                doneSeen = 1'b1;
            end else begin
                checkValue({testName, " message hold"}, lastResult, message);
            end
        end
        // Enable was still high at the edge after done when poking
        @(negedge clock);
        enable = 1'b0;
        checkValue({testName, " done width"}, 1'b0, done);
        checkValue({testName, " busy after done"}, 1'b0, busy);
        lastResult = expected;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(randomSeed));
        rstN       = 1'b0;
        enable     = 1'b0;
        inData     = 8'h00;
        keyByte    = 8'h00;
        lastResult = '0;

        startTest("reset state");
        repeat (resetCycles) @(negedge clock);
        checkValue("busy in reset", 1'b0, busy);
        checkValue("done in reset", 1'b0, done);
        checkValue("message in reset", '0, message);
        rstN = 1'b1;
        repeat (2) begin
            @(negedge clock);
            checkValue("busy after reset", 1'b0, busy);
            checkValue("done after reset", 1'b0, done);
            checkValue("message after reset", '0, message);
        end
        finishTest();

        startTest("known vector");
        checkValue("known vector reference", knownResult, aesRoundRef(knownPlain, knownKey));
        runBlock("known vector", knownPlain, knownKey, knownResult, 1'b0);
        finishTest();

        // SubBytes gives 63 everywhere and a constant column survives MixColumns
        startTest("all-zero block and key");
        checkValue("all-zero reference", {`AES_BYTES{8'h63}}, aesRoundRef('0, '0));
        runBlock("all-zero block", '0, '0, {`AES_BYTES{8'h63}}, 1'b0);
        finishTest();

        startTest("random blocks");
        for (int i = 0; i < randomRuns; i++) begin
            stimPlain = randomBlock();
            stimKey   = randomBlock();
            runBlock($sformatf("random block %0d", i), stimPlain, stimKey,
                     aesRoundRef(stimPlain, stimKey), 1'b0);
        end
        finishTest();

        startTest("enable while busy");
        stimPlain = randomBlock();
        stimKey   = randomBlock();
        runBlock("enable held high", stimPlain, stimKey, aesRoundRef(stimPlain, stimKey), 1'b1);
        // Result stays on message through an idle gap
        repeat (10) begin
            @(negedge clock);
            checkValue("idle message hold", lastResult, message);
            checkValue("idle busy", 1'b0, busy);
        end
        stimPlain = randomBlock();
        stimKey   = randomBlock();
        runBlock("run after held enable", stimPlain, stimKey,
                 aesRoundRef(stimPlain, stimKey), 1'b0);
        finishTest();

        $display("Summary: %0d tests ok, %0d tests failing, %0d check errors",
                 testsPassed, testsFailed, errorCount);
        if (errorCount == 0 && testsFailed == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog sized from the number of runs plus reset
    initial begin
        #(timeoutTime);
        $display("Timeout: done never arrived within %0d time units", timeoutTime);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== sim/clockGen.sv ====
module clockGen (
    output logic clock
);

    // Period of 8 time units
    localparam int halfPeriod = 4;

    initial begin
        clock = 1'b0;
    end

    always begin
        #halfPeriod clock = ~clock;
    end

endmodule

// ==== source/aesRoundCore.sv ====
`include "aes_defs.svh"

module aesRoundCore (
    input  logic                        clock,
    input  logic                        rstN,
    input  logic                        enable,
    input  logic [7:0]                  inData,
    input  logic [7:0]                  keyByte,
    output logic [`AES_STATE_WIDTH-1:0] message,
    output logic                        busy,
    output logic                        done
);
    import aesPkg::*;

    coreState_t                  state;
    coreState_t                  nextState;
    logic                        loadEn, loadLast;
    logic                        subStart, subLast;
    logic                        mixEn;
    logic [`AES_STATE_WIDTH-1:0] loadState, subState, mixState;

    ////////////////////////////////////////////////////////////////////////////
    // Sequencing FSM
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        nextState = state;
        case (state)
            IDLE:    if (enable)   nextState = LOAD;
            LOAD:    if (loadLast) nextState = SUBBYTE;
            SUBBYTE: if (subLast)  nextState = MIXCOL;
            // Done cycle, enable still ignored here
            MIXCOL:  nextState = IDLE;
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            state <= nextState;
            // High from the start edge through the done cycle
            busy  <= (nextState != IDLE);
            // Same edge as the mixed state register
            done  <= (state == SUBBYTE) && subLast;
        end
    end

    // Byte 0 is captured on the start edge itself
    // Nothing captured once the block is complete
    assign loadEn   = ((state == IDLE) && enable) || ((state == LOAD) && !loadLast);
    assign subStart = loadLast;
    assign mixEn    = subLast;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath stages
    ////////////////////////////////////////////////////////////////////////////

    keyXorLoader keyLoader (
        .clock     (clock),
        .rstN      (rstN),
        .loadEn    (loadEn),
        .inData    (inData),
        .keyByte   (keyByte),
        .loadState (loadState),
        .loadLast  (loadLast)
    );

    subBytesSerial subStage (
        .clock     (clock),
        .rstN      (rstN),
        .subStart  (subStart),
        .seedState (loadState),
        .subState  (subState),
        .subLast   (subLast)
    );

    shiftMixColumns mixStage (
        .clock    (clock),
        .rstN     (rstN),
        .mixEn    (mixEn),
        .stateIn  (subState),
        .mixState (mixState)
    );

    // Mix register holds the result until the next run completes
    assign message = mixState;

endmodule

// ==== source/shiftMixColumns.sv ====
`include "aes_defs.svh"

module shiftMixColumns (
    input  logic                        clock,
    input  logic                        rstN,
    input  logic                        mixEn,
    input  logic [`AES_STATE_WIDTH-1:0] stateIn,
    output logic [`AES_STATE_WIDTH-1:0] mixState
);
    import aesPkg::*;

    logic [7:0]                  inByte  [`AES_BYTES];
    logic [7:0]                  shifted [`AES_BYTES];
    logic [7:0]                  mixed   [`AES_BYTES];
    logic [`AES_STATE_WIDTH-1:0] mixedFlat;

    ////////////////////////////////////////////////////////////////////////////
    // Byte k sits at row k mod 4, column k div 4, first byte at the top
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < `AES_BYTES; k++) begin
            inByte[k] = stateIn[`AES_STATE_WIDTH-1-8*k -: 8];
        end

        // ShiftRows, row r rotated left by r columns
        for (int c = 0; c < `AES_BYTES / 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                shifted[4*c+r] = inByte[4*((c+r)%4)+r];
            end
        end

        // MixColumns, circulant rows 2 3 1 1
        // Times 3 is xtime plus the byte itself
        for (int c = 0; c < `AES_BYTES / 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                mixed[4*c+r] = xtime(shifted[4*c+r])
                             ^ xtime(shifted[4*c+(r+1)%4]) ^ shifted[4*c+(r+1)%4]
                             ^ shifted[4*c+(r+2)%4]
                             ^ shifted[4*c+(r+3)%4];
            end
        end

        for (int k = 0; k < `AES_BYTES; k++) begin
            mixedFlat[`AES_STATE_WIDTH-1-8*k -: 8] = mixed[k];
        end
    end

    // Result register, held between runs as the visible message
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            mixState <= '0;
        end else if (mixEn) begin
            mixState <= mixedFlat;
        end
    end

endmodule

// ==== source/subBytesSerial.sv ====
`include "aes_defs.svh"

module subBytesSerial (
    input  logic                        clock,
    input  logic                        rstN,
    input  logic                        subStart,
    input  logic [`AES_STATE_WIDTH-1:0] seedState,
    output logic [`AES_STATE_WIDTH-1:0] subState,
    output logic                        subLast
);

    logic [`AES_STATE_WIDTH-1:0] stateReg;
    logic [`AES_STATE_WIDTH-1:0] rotSrc;
    logic [`AES_CNT_WIDTH-1:0]   stepCnt;
    logic [7:0]                  sboxOut;
    logic                        stepEn;

    // Seed goes straight through the S-box at the start edge
    // That start edge is step one of sixteen
    assign rotSrc = subStart ? seedState : stateReg;
    assign stepEn = subStart || (stepCnt != '0);

    // Single shared S-box on the top byte
    aesSbox sbox (
        .byteIn  (rotSrc[`AES_STATE_WIDTH-1 -: 8]),
        .byteOut (sboxOut)
    );

    // Substituted byte drops to the bottom
    // Sixteen rotations put every byte back in place
    always_ff @(posedge clock) begin
        if (stepEn) begin
            stateReg <= {rotSrc[`AES_STATE_WIDTH-9:0], sboxOut};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Step counter, nonzero while a run is in progress
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            stepCnt <= '0;
            subLast <= 1'b0;
        end else begin
            if (subStart) begin
                stepCnt <= `AES_CNT_WIDTH'(1);
            end else if (stepCnt != '0) begin
                stepCnt <= stepCnt + 1'b1;
            end
            // Count 15 means the sixteenth step is on this edge
            subLast <= !subStart && (stepCnt == `AES_CNT_WIDTH'(`AES_BYTES - 1));
        end
    end

    assign subState = stateReg;

endmodule

// ==== source/keyXorLoader.sv ====
`include "aes_defs.svh"

module keyXorLoader (
    input  logic                        clock,
    input  logic                        rstN,
    input  logic                        loadEn,
    input  logic [7:0]                  inData,
    input  logic [7:0]                  keyByte,
    output logic [`AES_STATE_WIDTH-1:0] loadState,
    output logic                        loadLast
);

    ////////////////////////////////////////////////////////////////////////////
    // Byte counter
    ////////////////////////////////////////////////////////////////////////////

    logic [`AES_CNT_WIDTH-1:0] byteCnt;
    logic                      lastByte;

    // Sixteenth byte of the block is being captured
    assign lastByte = loadEn && (byteCnt == `AES_CNT_WIDTH'(`AES_BYTES - 1));

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            byteCnt  <= '0;
            loadLast <= 1'b0;
        end else begin
            // Wraps to zero after the last byte
            if (loadEn) begin
                byteCnt <= byteCnt + 1'b1;
            end
            // One-cycle pulse once the block is complete
            loadLast <= lastByte;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Initial AddRoundKey shift register
    ////////////////////////////////////////////////////////////////////////////

    logic [`AES_STATE_WIDTH-1:0] xorState;

    // New byte enters at the bottom, oldest byte ends up at the top
    always_ff @(posedge clock) begin
        if (loadEn) begin
            xorState <= {xorState[`AES_STATE_WIDTH-9:0], inData ^ keyByte};
        end
    end

    // Held after the last byte for the substitution stage
    assign loadState = xorState;

endmodule

// ==== source/aesSbox.sv ====
module aesSbox (
    input  logic [7:0] byteIn,
    output logic [7:0] byteOut
);
    import aesPkg::*;

    // Shift-and-add product, one xtime per bit of b
    function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] term;
        acc  = 8'h00;
        term = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ term;
            end
            term = xtime(term);
        end
        return acc;
    endfunction

    // Power chain towards x^254, which is the inverse (and maps 0 to 0)
    logic [7:0] p2, p3, p6, p12, p15, p30, p60, p120, p240, p252, inv;

    assign p2   = gfMul(byteIn, byteIn);
    assign p3   = gfMul(p2, byteIn);
    assign p6   = gfMul(p3, p3);
    assign p12  = gfMul(p6, p6);
    assign p15  = gfMul(p12, p3);
    assign p30  = gfMul(p15, p15);
    assign p60  = gfMul(p30, p30);
    assign p120 = gfMul(p60, p60);
    assign p240 = gfMul(p120, p120);
    assign p252 = gfMul(p240, p12);
    assign inv  = gfMul(p252, p2);

    // Affine transform
    // XOR of the inverse with its four left rotations, then constant 0x63
    assign byteOut = inv
                   ^ {inv[6:0], inv[7]}
                   ^ {inv[5:0], inv[7:6]}
                   ^ {inv[4:0], inv[7:5]}
                   ^ {inv[3:0], inv[7:4]}
                   ^ 8'h63;

endmodule

// ==== source/aesPkg.sv ====
package aesPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Top-level sequencing FSM
    ////////////////////////////////////////////////////////////////////////////

    // Load bytes, substitute bytes, then one mixing step
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        SUBBYTE,
        MIXCOL
    } coreState_t;

    ////////////////////////////////////////////////////////////////////////////
    // GF(2^8) arithmetic
    ////////////////////////////////////////////////////////////////////////////

    // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1B : 8'h00);
    endfunction

endpackage

// ==== source/aes_defs.svh ====
`ifndef AES_DEFS_SVH
`define AES_DEFS_SVH

// AES block geometry
// Full state, 16 bytes column-major
`define AES_STATE_WIDTH 128

// Bytes per block
`define AES_BYTES 16

// Byte counters wrap after 16 steps
`define AES_CNT_WIDTH 4

`endif
